// File: icache_top.f
icache_pkg.sv
fetch_if.sv
refill_if.sv
fetch_front.sv
icache_core.sv
axi_refill_master.sv
icache_top.sv
tb_clock_gen.sv
tb_axi_mem_model.sv
tb_icache_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_icache_top
FLIST     ?= icache_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FLIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	$(BIN) | tee /dev/stderr | grep -qF "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_icache_top.sv
`timescale 1ns/1ps

module tb_icache_top import icache_pkg::*; ();

    localparam int WORDS_PER_LINE = 8;
    localparam int LINE_COUNT     = 64;
    localparam int HIT_LATENCY    = 4;
    localparam int WAIT_LIMIT     = 2000;
    localparam int RANDOM_FETCHES = 300;

    logic aclk;
    logic global_reset;
    logic fetch_req;
    addr_t fetch_addr;
    logic fetch_ack;
    word_t fetch_data;
    logic [AXI_ID_W-1:0] arid;
    addr_t araddr;
    logic [AXI_LEN_W-1:0] arlen;
    logic [2:0] arsize;
    logic [1:0] arburst;
    logic arvalid;
    logic arready;
    logic [AXI_ID_W-1:0] rid;
    word_t rdata;
    logic [1:0] rresp;
    logic rlast;
    logic rvalid;
    logic rready;
    int model_errors;

    int errors = 0;
    int checks = 0;
    int ar_count = 0;
    bit hung = 1'b0;
    addr_t last_araddr;
    logic [AXI_LEN_W-1:0] last_arlen;
    logic [1:0] last_arburst;
    logic [2:0] last_arsize;
    logic [AXI_ID_W-1:0] last_arid;
    addr_t exp_addr_q[$];
    string name_q[$];

    tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(10)) clock_gen (
        .aclk(aclk), .global_reset(global_reset)
    );

    icache_top #(.WORDS_PER_LINE(WORDS_PER_LINE), .LINE_COUNT(LINE_COUNT)) DUT (
        .aclk(aclk), .global_reset(global_reset),
        .i_fetch_req(fetch_req), .i_fetch_addr(fetch_addr),
        .o_fetch_ack(fetch_ack), .o_fetch_data(fetch_data),
        .o_arid(arid), .o_araddr(araddr), .o_arlen(arlen), .o_arsize(arsize),
        .o_arburst(arburst), .o_arvalid(arvalid), .i_arready(arready),
        .i_rid(rid), .i_rdata(rdata), .i_rresp(rresp), .i_rlast(rlast),
        .i_rvalid(rvalid), .o_rready(rready)
    );

    tb_axi_mem_model mem_model (
        .aclk(aclk), .global_reset(global_reset),
        .i_arid(arid), .i_araddr(araddr), .i_arlen(arlen), .i_arvalid(arvalid),
        .o_arready(arready), .o_rid(rid), .o_rdata(rdata), .o_rresp(rresp),
        .o_rlast(rlast), .o_rvalid(rvalid), .i_rready(rready),
        .o_stall_errors(model_errors)
    );

    // expected memory word at a byte address
    function automatic word_t mem_word(input addr_t a);
        return {a[15:0] ^ 16'ha5c3, ~a[15:0]};
    endfunction

    // segment bits are simply cleared
    function automatic addr_t phys_addr(input addr_t va);
        return {3'b000, va[28:0]};
    endfunction

    task automatic check_equal(input string name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s %s expected %h actual %h", name, what, exp, act);
        end
    endtask

    task automatic check_ar(input string name, input int exp_count, input addr_t exp_addr,
                            input int exp_len);
        check_equal(name, "ar count", exp_count, ar_count);
        check_equal(name, "araddr", exp_addr, last_araddr);
        check_equal(name, "arlen", exp_len, 32'(last_arlen));
        check_equal(name, "arburst", 32'h1, 32'(last_arburst));
        check_equal(name, "arsize", 32'h2, 32'(last_arsize));
        check_equal(name, "arid", 32'h0, 32'(last_arid));
    endtask

    // entered and left just after a rising edge
    task automatic do_fetch(input addr_t va, input string name, input int exp_lat);
        int lat;
        int hold;
        if (!hung) begin
            fetch_addr = va;
            fetch_req  = 1'b1;
            exp_addr_q.push_back(phys_addr(va));
            name_q.push_back(name);
            @(posedge aclk);
            #1;
            lat = 0;
            while (fetch_ack !== 1'b1 && lat < WAIT_LIMIT) begin
                @(posedge aclk);
                #1;
                lat++;
            end
            if (fetch_ack !== 1'b1) begin
                errors++;
                hung = 1'b1;
                $display("%s: no ack from the DUT within %0d cycles", name, WAIT_LIMIT);
            end else if (exp_lat > 0) begin
                check_equal(name, "ack latency", exp_lat, lat);
            end
            // the core may keep req up for a while after ack
            hold = $urandom % 3;
            repeat (hold) begin
                @(posedge aclk);
                #1;
            end
            fetch_req = 1'b0;
            lat = 0;
            while (fetch_ack !== 1'b0 && lat < WAIT_LIMIT) begin
                @(posedge aclk);
                #1;
                lat++;
            end
            if (fetch_ack !== 1'b0 && !hung) begin
                errors++;
                hung = 1'b1;
                $display("%s: ack stayed high after req was dropped", name);
            end
        end
    endtask

    initial begin : ar_monitor
        forever begin
            @(negedge aclk);
            if (!global_reset && arvalid && arready) begin
                ar_count++;
                last_araddr  = araddr;
                last_arlen   = arlen;
                last_arburst = arburst;
                last_arsize  = arsize;
                last_arid    = arid;
            end
        end
    end

    initial begin : compare_loop
        addr_t exp_pa;
        string nm;
        logic  ack_prev;
        logic  req_prev;
        ack_prev = 1'b0;
        req_prev = 1'b0;
        forever begin
            @(negedge aclk);
            // req_prev is req as the DUT saw it at the edge that moved ack
            if (!global_reset && fetch_ack === 1'b1 && !ack_prev) begin
                if (req_prev !== 1'b1) begin
                    errors++;
                    $display("ack rose while req was low");
                end
                if (exp_addr_q.size() == 0) begin
                    errors++;
                    $display("ack seen with no fetch outstanding");
                end else begin
                    exp_pa = exp_addr_q.pop_front();
                    nm = name_q.pop_front();
                    check_equal(nm, "data", mem_word(exp_pa), fetch_data);
                end
            end
            if (!global_reset && fetch_ack === 1'b0 && ack_prev && req_prev === 1'b1) begin
                errors++;
                $display("ack fell while req was still high");
            end
            ack_prev = (fetch_ack === 1'b1);
            req_prev = fetch_req;
        end
    end

    initial begin : stimulus
        int n;
        addr_t va;
        void'($urandom(32'h375c_1c8c));
        fetch_req  = 1'b0;
        fetch_addr = '0;
        n = 0;
        // first edge puts the outputs in reset
        @(posedge aclk);
        while (global_reset !== 1'b0 && n < WAIT_LIMIT) begin
            @(negedge aclk);
            n++;
            check_equal("reset", "ack arvalid rready", 32'd0, {29'd0, fetch_ack, arvalid, rready});
        end
        if (global_reset !== 1'b0) begin
            errors++;
            hung = 1'b1;
            $display("reset was never released");
        end
        @(posedge aclk);
        #1;
        check_equal("after_reset", "ack arvalid rready", 32'd0, {29'd0, fetch_ack, arvalid, rready});

        do_fetch(32'h8000_1234, "cold_miss", 0);
        check_ar("cold_miss", 1, 32'h0000_1220, 7);
        for (n = 0; n < WORDS_PER_LINE; n++) begin
            va = 32'h8000_1220 + 32'(n * 4);
            if (va != 32'h8000_1234) begin
                do_fetch(va, "hit", HIT_LATENCY);
            end
        end
        check_equal("hit", "ar count", 32'd1, ar_count);

        // same index, other tag
        do_fetch(32'h8000_1a34, "conflict", 0);
        check_ar("conflict", 2, 32'h0000_1a20, 7);
        do_fetch(32'h8000_1234, "refetch", 0);
        check_ar("refetch", 3, 32'h0000_1220, 7);

        for (n = 0; n < 3; n++) begin
            do_fetch(32'ha000_2468, "uncached", 0);
            check_ar("uncached", 4 + n, 32'h0000_2468, 0);
        end

        for (n = 0; n < RANDOM_FETCHES; n++) begin
            va = {($urandom % 4 == 0) ? 3'b101 : 3'b100, 15'd0, 12'($urandom), 2'b00};
            do_fetch(va, "random", 0);
        end

        check_equal("end", "pending fetches", 32'd0, exp_addr_q.size());
        errors += model_errors;
        $display("summary: %0d checks, %0d errors, %0d AR handshakes", checks, errors, ar_count);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: tb_axi_mem_model.sv
`timescale 1ns/1ps

module tb_axi_mem_model import icache_pkg::*; #(
    parameter int MAX_DELAY = 4,
    parameter int TIMEOUT   = 1000
) (
    input  logic                 aclk,
    input  logic                 global_reset,
    input  logic [AXI_ID_W-1:0]  i_arid,
    input  addr_t                i_araddr,
    input  logic [AXI_LEN_W-1:0] i_arlen,
    input  logic                 i_arvalid,
    output logic                 o_arready,
    output logic [AXI_ID_W-1:0]  o_rid,
    output word_t                o_rdata,
    output logic [1:0]           o_rresp,
    output logic                 o_rlast,
    output logic                 o_rvalid,
    input  logic                 i_rready,
    output int                   o_stall_errors
);

    addr_t                burst_addr;
    logic [AXI_LEN_W-1:0] burst_len;
    int                   gap;
    int                   wait_cnt;

    // memory contents are a function of the byte address
    function automatic word_t stored_word(input addr_t a);
        return {a[15:0] ^ 16'ha5c3, ~a[15:0]};
    endfunction

    initial begin
        o_arready      = 1'b0;
        o_rid          = '0;
        o_rdata        = '0;
        o_rresp        = 2'b00;
        o_rlast        = 1'b0;
        o_rvalid       = 1'b0;
        o_stall_errors = 0;
        forever begin
            @(negedge aclk);
            if (!global_reset && i_arvalid) begin
                repeat (1 + $urandom % MAX_DELAY) @(posedge aclk);
                #1;
                o_arready  = 1'b1;
                burst_addr = i_araddr;
                burst_len  = i_arlen;
                o_rid      = i_arid;
                @(posedge aclk);
                #1;
                o_arready = 1'b0;
                for (int beat = 0; beat <= int'(burst_len); beat++) begin
                    gap = $urandom % MAX_DELAY;
                    repeat (gap) begin
                        @(posedge aclk);
                        #1;
                    end
                    o_rvalid = 1'b1;
                    o_rdata  = stored_word(burst_addr + beat * 4);
                    o_rlast  = (beat == int'(burst_len));
                    wait_cnt = 0;
                    @(negedge aclk);
                    while (!i_rready && wait_cnt < TIMEOUT) begin
                        @(negedge aclk);
                        wait_cnt++;
                    end
                    if (!i_rready) begin
                        o_stall_errors++;
                        $display("memory model: rready stayed low for beat %0d", beat);
                    end
                    @(posedge aclk);
                    #1;
                    o_rvalid = 1'b0;
                    o_rlast  = 1'b0;
                end
            end
        end
    end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic aclk,
    output logic global_reset
);

    initial begin
        aclk = 1'b0;
        forever #(PERIOD_NS / 2) aclk = ~aclk;
    end

    // release just after an edge, like all other stimulus
    initial begin
        global_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge aclk);
        #1;
        global_reset = 1'b0;
    end

endmodule

// File: icache_top.sv
`timescale 1ns/1ps

module icache_top import icache_pkg::*; #(
    parameter int WORDS_PER_LINE = 8,
    parameter int LINE_COUNT     = 64
) (
    input  logic                 aclk,
    input  logic                 global_reset,

    // core side fetch port
    input  logic                 i_fetch_req,
    input  addr_t                i_fetch_addr,
    output logic                 o_fetch_ack,
    output word_t                o_fetch_data,

    // axi read address channel
    output logic [AXI_ID_W-1:0]  o_arid,
    output addr_t                o_araddr,
    output logic [AXI_LEN_W-1:0] o_arlen,
    output logic [2:0]           o_arsize,
    output logic [1:0]           o_arburst,
    output logic                 o_arvalid,
    input  logic                 i_arready,

    // axi read data channel
    input  logic [AXI_ID_W-1:0]  i_rid,
    input  word_t                i_rdata,
    input  logic [1:0]           i_rresp,
    input  logic                 i_rlast,
    input  logic                 i_rvalid,
    output logic                 o_rready
);

    fetch_if  fetch_bus ();
    refill_if refill_bus ();

    fetch_front u_fetch_front (
        .aclk         (aclk),
        .global_reset (global_reset),
        .i_fetch_req  (i_fetch_req),
        .i_fetch_addr (i_fetch_addr),
        .o_fetch_ack  (o_fetch_ack),
        .o_fetch_data (o_fetch_data),
        .fetch        (fetch_bus.front)
    );

    icache_core #(
        .WORDS_PER_LINE (WORDS_PER_LINE),
        .LINE_COUNT     (LINE_COUNT)
    ) u_icache_core (
        .aclk         (aclk),
        .global_reset (global_reset),
        .fetch        (fetch_bus.cache),
        .refill       (refill_bus.cache)
    );

    axi_refill_master #(
        .WORDS_PER_LINE (WORDS_PER_LINE)
    ) u_axi_refill_master (
        .aclk         (aclk),
        .global_reset (global_reset),
        .refill       (refill_bus.master),
        .o_arid       (o_arid),
        .o_araddr     (o_araddr),
        .o_arlen      (o_arlen),
        .o_arsize     (o_arsize),
        .o_arburst    (o_arburst),
        .o_arvalid    (o_arvalid),
        .o_rready     (o_rready),
        .i_arready    (i_arready),
        .i_rid        (i_rid),
        .i_rdata      (i_rdata),
        .i_rresp      (i_rresp),
        .i_rlast      (i_rlast),
        .i_rvalid     (i_rvalid)
    );

endmodule

// File: axi_refill_master.sv
`timescale 1ns/1ps

module axi_refill_master import icache_pkg::*; #(
    parameter int WORDS_PER_LINE = 8
) (
    input  logic                 aclk,
    input  logic                 global_reset,

    refill_if.master             refill,

    output logic [AXI_ID_W-1:0]  o_arid,
    output addr_t                o_araddr,
    output logic [AXI_LEN_W-1:0] o_arlen,
    output logic [2:0]           o_arsize,
    output logic [1:0]           o_arburst,
    output logic                 o_arvalid,
    output logic                 o_rready,

    input  logic                 i_arready,
    input  logic [AXI_ID_W-1:0]  i_rid,
    input  word_t                i_rdata,
    input  logic [1:0]           i_rresp,
    input  logic                 i_rlast,
    input  logic                 i_rvalid
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA
    } master_state_t;

    master_state_t state;
    logic          beat_ok;

    assign o_arid    = FETCH_AXI_ID;
    assign o_arsize  = AXI_SIZE_WORD;
    assign o_arburst = AXI_BURST_INCR;

    // only beats of our own id count, rresp is not checked
    assign beat_ok = i_rvalid && o_rready && (i_rid == FETCH_AXI_ID);

    assign refill.beat_valid = beat_ok;
    assign refill.beat_data  = i_rdata;
    assign refill.beat_last  = i_rlast;

    always_ff @(posedge aclk) begin
        if (global_reset) begin
            state     <= ST_IDLE;
            o_arvalid <= 1'b0;
            o_rready  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (refill.req) begin
                        o_arvalid <= 1'b1;
                        state     <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (i_arready) begin
                        o_arvalid <= 1'b0;
                        o_rready  <= 1'b1;
                        state     <= ST_DATA;
                    end
                end
                default: begin
                    if (beat_ok && i_rlast) begin
                        o_rready <= 1'b0;
                        state    <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // address fields held until arready
    always_ff @(posedge aclk) begin
        if (state == ST_IDLE && refill.req) begin
            o_araddr <= {refill.line_addr[ADDR_W-BYTE_OFF_W-1:0], {BYTE_OFF_W{1'b0}}};
            o_arlen  <= refill.single ? '0 : AXI_LEN_W'(WORDS_PER_LINE - 1);
        end
    end

endmodule

// File: icache_core.sv
`timescale 1ns/1ps

module icache_core import icache_pkg::*; #(
    parameter int WORDS_PER_LINE = 8,
    parameter int LINE_COUNT     = 64
) (
    input  logic    aclk,
    input  logic    global_reset,

    fetch_if.cache  fetch,
    refill_if.cache refill
);

    localparam int WOFF_W  = $clog2(WORDS_PER_LINE);
    localparam int IDX_W   = $clog2(LINE_COUNT);
    localparam int IDX_LSB = BYTE_OFF_W + WOFF_W;
    localparam int TAG_LSB = IDX_LSB + IDX_W;
    localparam int TAG_W   = ADDR_W - TAG_LSB;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COMPARE,
        ST_REFILL
    } core_state_t;

    core_state_t state;

    logic [LINE_COUNT-1:0] valid_bits;
    logic [TAG_W-1:0]      tag_mem [LINE_COUNT];
    word_t                 data_mem [LINE_COUNT*WORDS_PER_LINE];

    logic [IDX_W-1:0]  idx;
    logic [WOFF_W-1:0] woff;
    logic [TAG_W-1:0]  tag;

    logic              rd_valid;
    logic [TAG_W-1:0]  rd_tag;
    word_t             rd_word;
    logic [WOFF_W-1:0] beat_cnt;

    logic hit;
    logic beat_take;
    logic fill_done;

    // paddr is held by the front for the whole lookup
    assign idx  = fetch.paddr[TAG_LSB-1:IDX_LSB];
    assign woff = fetch.paddr[IDX_LSB-1:BYTE_OFF_W];
    assign tag  = fetch.paddr[ADDR_W-1:TAG_LSB];

    assign hit       = fetch.cached && rd_valid && (rd_tag == tag);
    assign beat_take = (state == ST_REFILL) && refill.beat_valid;
    assign fill_done = beat_take && refill.beat_last && !refill.single;

    // arrays, synchronous read on lookup
    always_ff @(posedge aclk) begin
        if (fetch.lookup) begin
            rd_tag  <= tag_mem[idx];
            rd_word <= data_mem[{idx, woff}];
        end
        if (beat_take && !refill.single) begin
            data_mem[{idx, beat_cnt}] <= refill.beat_data;
        end
        if (fill_done) begin
            tag_mem[idx] <= tag;
        end
    end

    always_ff @(posedge aclk) begin
        if (global_reset) begin
            state      <= ST_IDLE;
            fetch.done <= 1'b0;
            refill.req <= 1'b0;
            valid_bits <= '0;
            rd_valid   <= 1'b0;
            beat_cnt   <= '0;
        end else begin
            fetch.done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (fetch.lookup) begin
                        rd_valid <= valid_bits[idx];
                        state    <= ST_COMPARE;
                    end
                end
                ST_COMPARE: begin
                    if (hit) begin
                        fetch.done <= 1'b1;
                        fetch.data <= rd_word;
                        state      <= ST_IDLE;
                    end else begin
                        refill.req    <= 1'b1;
                        refill.single <= !fetch.cached;
                        // uncached asks for the exact word only
                        if (fetch.cached) begin
                            refill.line_addr <= {2'b00, fetch.paddr[ADDR_W-1:IDX_LSB],
                                                 {WOFF_W{1'b0}}};
                        end else begin
                            refill.line_addr <= {2'b00, fetch.paddr[ADDR_W-1:BYTE_OFF_W]};
                        end
                        beat_cnt <= '0;
                        state    <= ST_REFILL;
                    end
                end
                default: begin
                    if (refill.beat_valid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (refill.single || beat_cnt == woff) begin
                            fetch.data <= refill.beat_data;
                        end
                        if (refill.beat_last) begin
                            refill.req <= 1'b0;
                            fetch.done <= 1'b1;
                            state      <= ST_IDLE;
                            if (!refill.single) begin
                                valid_bits[idx] <= 1'b1;
                            end
                        end
                    end
                end
            endcase
        end
    end

endmodule

// File: fetch_front.sv
`timescale 1ns/1ps

module fetch_front import icache_pkg::*; (
    input  logic    aclk,
    input  logic    global_reset,

    input  logic    i_fetch_req,
    input  addr_t   i_fetch_addr,
    output logic    o_fetch_ack,
    output word_t   o_fetch_data,

    fetch_if.front  fetch
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_ACK
    } front_state_t;

    front_state_t state;
    logic         issue;

    always_ff @(posedge aclk) begin
        if (global_reset) begin
            state        <= ST_IDLE;
            issue        <= 1'b0;
            fetch.lookup <= 1'b0;
            o_fetch_ack  <= 1'b0;
        end else begin
            // lookup goes out one cycle after the address is stored
            fetch.lookup <= issue;
            issue        <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_fetch_req) begin
                        issue <= 1'b1;
                        state <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    if (fetch.done) begin
                        o_fetch_ack <= 1'b1;
                        state       <= ST_ACK;
                    end
                end
                default: begin
                    // wait for the core to drop req
                    if (!i_fetch_req) begin
                        o_fetch_ack <= 1'b0;
                        state       <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // translated address, top segment bits cleared
    always_ff @(posedge aclk) begin
        if (state == ST_IDLE && i_fetch_req) begin
            fetch.paddr  <= {3'b000, i_fetch_addr[ADDR_W-4:0]};
            fetch.cached <= (i_fetch_addr[ADDR_W-1:ADDR_W-3] != UNCACHED_SEG);
        end
        if (state == ST_BUSY && fetch.done) begin
            o_fetch_data <= fetch.data;
        end
    end

endmodule

// File: refill_if.sv
`timescale 1ns/1ps

interface refill_if import icache_pkg::*; ();

    // word address, line aligned or exact word when single
    logic  req;
    addr_t line_addr;
    logic  single;

    // beats coming back from the bus
    logic  beat_valid;
    word_t beat_data;
    logic  beat_last;

    modport cache (
        output req,
        output line_addr,
        output single,
        input  beat_valid,
        input  beat_data,
        input  beat_last
    );

    modport master (
        input  req,
        input  line_addr,
        input  single,
        output beat_valid,
        output beat_data,
        output beat_last
    );

endinterface

// File: fetch_if.sv
`timescale 1ns/1ps

interface fetch_if import icache_pkg::*; ();

    // front to cache
    logic  lookup;
    addr_t paddr;
    logic  cached;

    // cache to front
    logic  done;
    word_t data;

    modport front (
        output lookup,
        output paddr,
        output cached,
        input  done,
        input  data
    );

    modport cache (
        input  lookup,
        input  paddr,
        input  cached,
        output done,
        output data
    );

endinterface

// File: icache_pkg.sv
package icache_pkg;

    // basic widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // bits of byte offset inside one word
    localparam int BYTE_OFF_W = 2;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] word_t;

    // axi read channel fields
    localparam int AXI_ID_W  = 4;
    localparam int AXI_LEN_W = 4;

    localparam logic [AXI_ID_W-1:0] FETCH_AXI_ID = '0;

    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [2:0] AXI_SIZE_WORD  = 3'b010;

    // kseg1-style segment, fetched around the cache
    localparam logic [2:0] UNCACHED_SEG = 3'b101;

endpackage
